// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_master_translator -f verilog.f \
   -o tb_master_translator || { echo "build failed"; exit 1; }

sim_output="$(./obj_dir/tb_master_translator 2>&1)"
printf '%s\n' "$sim_output"

printf '%s\n' "$sim_output" | grep -qx "No errors" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== src/burst_sequencer.sv ====
// keeps the next beat's byte address and the remaining word count across a write burst
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
   input logic     clk,
   input logic     reset,
   input logic     write,
   input logic     waitrequest,
   xlat_if.sequencer beat
);
   import xlat_cfg_pkg::*;
   import xlat_types_pkg::*;

   uav_addr_t next_address;
   uav_addr_t addr_q;
   burstlen_t burstlen_q;
   logic      first_stalled;
   logic      burst_stalled;

   // the beat on the bus uses fresh values on a burst start, else the held ones
   assign next_address = beat.begin_burst ? beat.fresh_address : addr_q;

   assign beat.reg_address = addr_q;
   assign beat.reg_burstlen = burstlen_q;

   // --------------------------------------------------
   // address register
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_q <= '0;
      end else if (waitrequest) begin
         // stalled beat keeps its own address
         addr_q <= next_address;
      end else if (write) begin
         addr_q <= next_address + uav_addr_t'(SYMBOLS_PER_WORD);
      end
   end

   // --------------------------------------------------
   // remaining words
   // --------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         burstlen_q <= '0;
      end else if (beat.begin_burst || first_stalled) begin
         if (waitrequest) begin
            burstlen_q <= beat.fresh_burstlen;
         end else begin
            burstlen_q <= beat.fresh_burstlen - burstlen_t'(1);
         end
      end else if (beat.begin_transfer || burst_stalled) begin
         if (!waitrequest) begin
            burstlen_q <= burstlen_q - burstlen_t'(1);
         end
      end
   end

   // --------------------------------------------------
   // stall tracking
   // --------------------------------------------------

   // first beat and later beats are tracked apart so each reloads the right value
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         first_stalled <= 1'b0;
         burst_stalled <= 1'b0;
      end else if (beat.begin_burst || first_stalled) begin
         first_stalled <= waitrequest;
      end else if (beat.begin_transfer || burst_stalled) begin
         burst_stalled <= waitrequest;
      end
   end

endmodule

`default_nettype wire

// ==== src/command_output.sv ====
// forms the outgoing byte address and symbol count from fresh or registered beat values
`timescale 1ns/1ps
`default_nettype none

module command_output (
   input  xlat_types_pkg::av_addr_t        address,
   input  xlat_types_pkg::av_burstcount_t  burstcount,
   xlat_if.out                             beat,
   output xlat_types_pkg::uav_addr_t       uav_address,
   output xlat_types_pkg::uav_burstcount_t uav_burstcount
);
   import xlat_cfg_pkg::*;
   import xlat_types_pkg::*;

   burstlen_t beat_burstlen;

   // --------------------------------------------------
   // word units to byte units
   // --------------------------------------------------

   // word address lands above the byte offset bits
   assign beat.fresh_address = uav_addr_t'(address) << BITS_PER_WORD;

   // count stays in words internally until it leaves the block
   assign beat.fresh_burstlen = burstlen_t'(burstcount);

   // --------------------------------------------------
   // output select
   // --------------------------------------------------
   always_comb begin
      if (beat.begin_burst) begin
         uav_address = beat.fresh_address;
         beat_burstlen = beat.fresh_burstlen;
      end else begin
         // later beats and stalled first beats use the held values
         uav_address = beat.reg_address;
         beat_burstlen = beat.reg_burstlen;
      end
   end

   // words to symbols
   assign uav_burstcount = uav_burstcount_t'(beat_burstlen) << BITS_PER_WORD;

endmodule

`default_nettype wire

// ==== src/master_translator.sv ====
// top level translating a word-addressed bursting master into a byte-addressed symbol-counted port
`timescale 1ns/1ps
`default_nettype none

module master_translator (
   input  logic                            clk,
   input  logic                            reset,

   // master side
   input  logic                            av_read,
   input  logic                            av_write,
   input  xlat_types_pkg::av_addr_t        av_address,
   input  xlat_types_pkg::av_burstcount_t  av_burstcount,
   input  xlat_types_pkg::data_t           av_writedata,
   input  xlat_types_pkg::byteenable_t     av_byteenable,
   output xlat_types_pkg::data_t           av_readdata,
   output logic                            av_readdatavalid,
   output logic                            av_waitrequest,

   // far side
   output logic                            uav_read,
   output logic                            uav_write,
   output xlat_types_pkg::uav_addr_t       uav_address,
   output xlat_types_pkg::uav_burstcount_t uav_burstcount,
   output xlat_types_pkg::data_t           uav_writedata,
   output xlat_types_pkg::byteenable_t     uav_byteenable,
   input  xlat_types_pkg::data_t           uav_readdata,
   input  logic                            uav_readdatavalid,
   input  logic                            uav_waitrequest
);

   xlat_if beat ();

   // --------------------------------------------------
   // pass-through paths
   // --------------------------------------------------
   assign uav_read = av_read;
   assign uav_write = av_write;
   assign uav_writedata = av_writedata;
   assign uav_byteenable = av_byteenable;

   assign av_readdata = uav_readdata;
   assign av_readdatavalid = uav_readdatavalid;
   assign av_waitrequest = uav_waitrequest;

   // --------------------------------------------------
   // begin pulses
   // --------------------------------------------------
   transfer_tracker u_tracker (
      .clk         (clk),
      .reset       (reset),
      .read        (av_read),
      .write       (av_write),
      .waitrequest (uav_waitrequest),
      .beat        (beat.tracker)
   );

   // --------------------------------------------------
   // per-beat address and count
   // --------------------------------------------------
   burst_sequencer u_sequencer (
      .clk         (clk),
      .reset       (reset),
      .write       (av_write),
      .waitrequest (uav_waitrequest),
      .beat        (beat.sequencer)
   );

   // --------------------------------------------------
   // outgoing command
   // --------------------------------------------------
   command_output u_cmd_out (
      .address        (av_address),
      .burstcount     (av_burstcount),
      .beat           (beat.out),
      .uav_address    (uav_address),
      .uav_burstcount (uav_burstcount)
   );

endmodule

`default_nettype wire

// ==== src/transfer_tracker.sv ====
// derives the begin-transfer and begin-burst pulses from the command strobes and waitrequest
`timescale 1ns/1ps
`default_nettype none

module transfer_tracker (
   input logic   clk,
   input logic   reset,
   input logic   read,
   input logic   write,
   input logic   waitrequest,
   xlat_if.tracker beat
);
   import xlat_types_pkg::*;

   logic end_begin_transfer;
   logic end_begin_burst;
   logic last_beat;

   // --------------------------------------------------
   // begin pulses
   // --------------------------------------------------

   // high from the first cycle of a command until it is accepted
   assign beat.begin_transfer = (read | write) & ~end_begin_transfer;

   // a read is always a burst of its own
   assign beat.begin_burst = read ? beat.begin_transfer
                                  : beat.begin_transfer & ~end_begin_burst;

   // first beat has no registered count yet
   assign last_beat = beat.begin_burst ? (beat.fresh_burstlen == burstlen_t'(1))
                                       : (beat.reg_burstlen == burstlen_t'(1));

   // --------------------------------------------------
   // state flags
   // --------------------------------------------------

   // set while a command sits stalled after its first cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begin_transfer <= 1'b0;
      end else if (beat.begin_transfer && waitrequest) begin
         end_begin_transfer <= 1'b1;
      end else if (!waitrequest) begin
         end_begin_transfer <= 1'b0;
      end
   end

   // set once a write burst is past its first beat
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begin_burst <= 1'b0;
      end else if ((last_beat && beat.begin_transfer) || read) begin
         end_begin_burst <= 1'b0;
      end else if (write && beat.begin_transfer) begin
         end_begin_burst <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== src/xlat_cfg_pkg.sv ====
// port widths and symbol constants shared by every module of the master translator
`default_nettype none

package xlat_cfg_pkg;

   // --------------------------------------------------
   // master side, word addressed and word counted
   // --------------------------------------------------
   localparam int AV_ADDRESS_W = 30;
   // a burst holds at most 8 words
   localparam int AV_BURSTCOUNT_W = 4;

   // --------------------------------------------------
   // far side, byte addressed and symbol counted
   // --------------------------------------------------
   localparam int UAV_ADDRESS_W = 32;
   localparam int UAV_BURSTCOUNT_W = 6;

   // --------------------------------------------------
   // data path and unit conversion
   // --------------------------------------------------
   localparam int DATA_W = 32;
   localparam int SYMBOLS_PER_WORD = 4;

   // shift between word units and byte units
   localparam int BITS_PER_WORD = 2;

   // remaining words of a write burst
   localparam int BURSTLEN_W = 4;

endpackage

`default_nettype wire

// ==== src/xlat_if.sv ====
// beat control plus fresh and registered address and count, shared by the translator internals
`timescale 1ns/1ps
`default_nettype none

interface xlat_if;
   import xlat_types_pkg::*;

   // begin pulses for the current beat
   logic begin_transfer;
   logic begin_burst;

   // values straight from the master command, already in byte units
   uav_addr_t fresh_address;
   burstlen_t fresh_burstlen;

   // values held for the next beat of a write burst
   uav_addr_t reg_address;
   burstlen_t reg_burstlen;

   modport tracker (
      output begin_transfer,
      output begin_burst,
      input  fresh_burstlen,
      input  reg_burstlen
   );

   modport sequencer (
      input  begin_transfer,
      input  begin_burst,
      input  fresh_address,
      input  fresh_burstlen,
      output reg_address,
      output reg_burstlen
   );

   modport out (
      input  begin_burst,
      input  reg_address,
      input  reg_burstlen,
      output fresh_address,
      output fresh_burstlen
   );

endinterface

`default_nettype wire

// ==== src/xlat_types_pkg.sv ====
// vector types for addresses, counts, data and byte enables of the master translator
`default_nettype none

package xlat_types_pkg;

   // addresses in word and byte units
   typedef logic [xlat_cfg_pkg::AV_ADDRESS_W-1:0] av_addr_t;
   typedef logic [xlat_cfg_pkg::UAV_ADDRESS_W-1:0] uav_addr_t;

   // burst length at the master port, in words
   typedef logic [xlat_cfg_pkg::AV_BURSTCOUNT_W-1:0] av_burstcount_t;

   // burst length on the far side, in symbols
   typedef logic [xlat_cfg_pkg::UAV_BURSTCOUNT_W-1:0] uav_burstcount_t;

   // words still to go inside a burst
   typedef logic [xlat_cfg_pkg::BURSTLEN_W-1:0] burstlen_t;

   // data word and one enable per byte
   typedef logic [xlat_cfg_pkg::DATA_W-1:0] data_t;
   typedef logic [xlat_cfg_pkg::SYMBOLS_PER_WORD-1:0] byteenable_t;

endpackage

`default_nettype wire

// ==== verif/tb_checks.svh ====
// compare tasks and the failure stop for the master translator testbench, included in its body
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// failure stop
// --------------------------------------------------
task automatic stop_on_failure();
   $display("Errors found");
   $fatal(1);
endtask

// --------------------------------------------------
// compare tasks, one per kind of result
// --------------------------------------------------
task automatic check_addr(input string test, input uav_addr_t expected,
                          input uav_addr_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
      stop_on_failure();
   end
endtask

task automatic check_count(input string test, input uav_burstcount_t expected,
                           input uav_burstcount_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
      stop_on_failure();
   end
endtask

task automatic check_data(input string test, input data_t expected, input data_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, expected, actual);
      stop_on_failure();
   end
endtask

task automatic check_enable(input string test, input byteenable_t expected,
                            input byteenable_t actual);
   if (actual !== expected) begin
      $display("[ERROR] %s: expected 4'b%04b, actual 4'b%04b", test, expected, actual);
      stop_on_failure();
   end
endtask

task automatic check_bit(input string test, input logic expected, input logic actual);
   if (actual !== expected) begin
      $display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
      stop_on_failure();
   end
endtask

`endif

// ==== verif/tb_master_translator.sv ====
// testbench for the master translator, walks a table of read and write bursts with random stalls
`timescale 1ns/1ps
`default_nettype none

module tb_master_translator;
   import xlat_cfg_pkg::*;
   import xlat_types_pkg::*;

   localparam int NUM_TESTS = 10;
   localparam int RESET_CYCLES = 8;
   localparam int MAX_WORDS = 8;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * MAX_WORDS * 4 + RESET_CYCLES;
   localparam int MAX_STALL_RUN = 2;
   localparam int unsigned RAND_SEED = 32'hc49e1ecf;

   logic            clk;
   logic            reset;
   logic            av_read;
   logic            av_write;
   av_addr_t        av_address;
   av_burstcount_t  av_burstcount;
   data_t           av_writedata;
   byteenable_t     av_byteenable;
   data_t           av_readdata;
   logic            av_readdatavalid;
   logic            av_waitrequest;
   logic            uav_read;
   logic            uav_write;
   uav_addr_t       uav_address;
   uav_burstcount_t uav_burstcount;
   data_t           uav_writedata;
   byteenable_t     uav_byteenable;
   data_t           uav_readdata;
   logic            uav_readdatavalid;
   logic            uav_waitrequest;

   // stimulus table, one column per array
   string          test_name [NUM_TESTS];
   logic           is_read [NUM_TESTS];
   av_addr_t       word_addr [NUM_TESTS];
   av_burstcount_t word_count [NUM_TESTS];
   data_t          wdata_seed [NUM_TESTS];
   data_t          rdata_value [NUM_TESTS];

   int          cycle_count = 0;
   int          stall_run = 0;
   int          stall_cycles = 0;

   `include "tb_checks.svh"

   master_translator uut (
      .clk               (clk),
      .reset             (reset),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_address        (av_address),
      .av_burstcount     (av_burstcount),
      .av_writedata      (av_writedata),
      .av_byteenable     (av_byteenable),
      .av_readdata       (av_readdata),
      .av_readdatavalid  (av_readdatavalid),
      .av_waitrequest    (av_waitrequest),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_address       (uav_address),
      .uav_burstcount    (uav_burstcount),
      .uav_writedata     (uav_writedata),
      .uav_byteenable    (uav_byteenable),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_waitrequest   (uav_waitrequest)
   );

   // 40 ns period
   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         stop_on_failure();
      end
   end

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   task automatic set_entry(input int idx, input string name, input logic rd,
                            input av_addr_t a, input av_burstcount_t n,
                            input data_t ws, input data_t rv);
      test_name[idx] = name;
      is_read[idx] = rd;
      word_addr[idx] = a;
      word_count[idx] = n;
      wdata_seed[idx] = ws;
      rdata_value[idx] = rv;
   endtask

   task automatic fill_table();
      set_entry(0, "write_burst_8", 1'b0, 30'h0000_0100, 4'd8, 32'h1111_0000, 32'h0);
      // single word right after the long burst, must restart from its own address
      set_entry(1, "write_single_after_burst", 1'b0, 30'h0000_0200, 4'd1, 32'h2222_0000, 32'h0);
      set_entry(2, "read_burst_4", 1'b1, 30'h0000_0300, 4'd4, 32'h0, 32'hcafe_0000);
      set_entry(3, "write_burst_3", 1'b0, 30'h0000_0040, 4'd3, 32'h3333_00f0, 32'h0);
      set_entry(4, "write_burst_5", 1'b0, 30'h2000_0000, 4'd5, 32'h4444_1234, 32'h0);
      set_entry(5, "read_single_top", 1'b1, 30'h3fff_ffff, 4'd1, 32'h0, 32'h8000_0001);
      set_entry(6, "write_burst_2", 1'b0, 30'h0abc_def0, 4'd2, 32'h5555_aaaa, 32'h0);
      set_entry(7, "write_single", 1'b0, 30'h0000_0001, 4'd1, 32'h6666_0f0f, 32'h0);
      set_entry(8, "read_burst_8", 1'b1, 30'h1234_5678, 4'd8, 32'h0, 32'h5a5a_0000);
      set_entry(9, "write_burst_7", 1'b0, 30'h0fff_fff8, 4'd7, 32'h7777_8888, 32'h0);
   endtask

   task automatic drive_idle();
      av_read = 1'b0;
      av_write = 1'b0;
      av_address = '0;
      av_burstcount = '0;
      av_writedata = '0;
      av_byteenable = '0;
      uav_readdata = '0;
      uav_readdatavalid = 1'b0;
      uav_waitrequest = 1'b0;
   endtask

   // random far-side stall, never more than MAX_STALL_RUN in a row
   task automatic pick_stall(output logic stall);
      if (stall_run >= MAX_STALL_RUN) begin
         stall = 1'b0;
      end else begin
         stall = ($urandom % 3) == 0;
      end
      if (stall) begin
         stall_run = stall_run + 1;
         stall_cycles = stall_cycles + 1;
      end else begin
         stall_run = 0;
      end
   endtask

   // --------------------------------------------------
   // one write burst, beat k expects A*4 + 4k and 4*(N-k) symbols
   // --------------------------------------------------
   task automatic run_write(input int idx);
      int              n;
      int              k;
      logic            stall;
      data_t           wdata;
      byteenable_t     be;
      uav_addr_t       exp_addr;
      uav_burstcount_t exp_count;
      n = int'(word_count[idx]);
      k = 0;
      while (k < n) begin
         @(posedge clk);
         #2;
         pick_stall(stall);
         wdata = wdata_seed[idx] ^ (data_t'(k) * data_t'(32'h0101_0101));
         be = byteenable_t'(k) ^ wdata_seed[idx][3:0];
         drive_idle();
         av_write = 1'b1;
         av_address = word_addr[idx];
         av_burstcount = word_count[idx];
         av_writedata = wdata;
         av_byteenable = be;
         uav_waitrequest = stall;
         @(negedge clk);
         exp_addr = uav_addr_t'(word_addr[idx]) * 4 + uav_addr_t'(4 * k);
         exp_count = uav_burstcount_t'(4 * (n - k));
         check_addr({test_name[idx], " uav_address"}, exp_addr, uav_address);
         check_count({test_name[idx], " uav_burstcount"}, exp_count, uav_burstcount);
         check_bit({test_name[idx], " uav_write"}, 1'b1, uav_write);
         check_bit({test_name[idx], " uav_read"}, 1'b0, uav_read);
         check_bit({test_name[idx], " av_waitrequest"}, stall, av_waitrequest);
         check_data({test_name[idx], " uav_writedata"}, wdata, uav_writedata);
         check_enable({test_name[idx], " uav_byteenable"}, be, uav_byteenable);
         check_bit({test_name[idx], " av_readdatavalid"}, 1'b0, av_readdatavalid);
         if (!stall) begin
            k = k + 1;
         end
      end
   endtask

   // --------------------------------------------------
   // one read, then N data words from the slave model
   // --------------------------------------------------
   task automatic run_read(input int idx);
      int              n;
      int              i;
      logic            stall;
      logic            accepted;
      data_t           rword;
      uav_addr_t       exp_addr;
      uav_burstcount_t exp_count;
      n = int'(word_count[idx]);
      exp_addr = uav_addr_t'(word_addr[idx]) * 4;
      exp_count = uav_burstcount_t'(4 * n);
      accepted = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         #2;
         pick_stall(stall);
         drive_idle();
         av_read = 1'b1;
         av_address = word_addr[idx];
         av_burstcount = word_count[idx];
         uav_waitrequest = stall;
         @(negedge clk);
         check_bit({test_name[idx], " uav_read"}, 1'b1, uav_read);
         check_bit({test_name[idx], " uav_write"}, 1'b0, uav_write);
         check_addr({test_name[idx], " uav_address"}, exp_addr, uav_address);
         check_count({test_name[idx], " uav_burstcount"}, exp_count, uav_burstcount);
         check_bit({test_name[idx], " av_waitrequest"}, stall, av_waitrequest);
         accepted = !stall;
      end
      for (i = 0; i < n; i = i + 1) begin
         @(posedge clk);
         #2;
         drive_idle();
         rword = rdata_value[idx] + data_t'(i);
         uav_readdata = rword;
         uav_readdatavalid = 1'b1;
         @(negedge clk);
         check_data({test_name[idx], " av_readdata"}, rword, av_readdata);
         check_bit({test_name[idx], " av_readdatavalid"}, 1'b1, av_readdatavalid);
      end
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      int idx;
      void'($urandom(RAND_SEED));
      clk = 1'b0;
      reset = 1'b1;
      drive_idle();
      fill_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      reset = 1'b0;
      for (idx = 0; idx < NUM_TESTS; idx = idx + 1) begin
         if (is_read[idx]) begin
            run_read(idx);
         end else begin
            run_write(idx);
         end
      end
      @(posedge clk);
      #2;
      drive_idle();
      @(negedge clk);
      if (stall_cycles == 0) begin
         $display("the run generated no far-side stall, so back-pressure went untested");
         stop_on_failure();
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verif
src/xlat_cfg_pkg.sv
src/xlat_types_pkg.sv
src/xlat_if.sv
src/transfer_tracker.sv
src/burst_sequencer.sv
src/command_output.sv
src/master_translator.sv
verif/tb_master_translator.sv
